/* hdl/fbc_cfg.svh */
`ifndef FBC_CFG_SVH
`define FBC_CFG_SVH

// channel layout and word widths on the write side
`define FBC_DS_CHANNELS 8
`define FBC_DS_WORD_W   32
`define FBC_AT_WORD_W   16
`define FBC_BYTE_W      8

// FIFO depths in write words
`define FBC_DS_DEPTH    64
`define FBC_AT_DEPTH    128

// count widths, words on the write side and bytes on the read side
`define FBC_DS_WCNT_W   ($clog2(`FBC_DS_DEPTH) + 1)
`define FBC_AT_WCNT_W   ($clog2(`FBC_AT_DEPTH) + 1)
`define FBC_DS_RCNT_W   ($clog2(`FBC_DS_DEPTH * `FBC_DS_WORD_W / `FBC_BYTE_W) + 1)
`define FBC_AT_RCNT_W   ($clog2(`FBC_AT_DEPTH * `FBC_AT_WORD_W / `FBC_BYTE_W) + 1)

`endif

/* hdl/fbc_pkg.sv */
`include "fbc_cfg.svh"

package fbc_pkg;

	// tags 0 to 7 name the DS channels, the next one names AT
	typedef logic [3:0] src_t;

	localparam src_t SRC_AT = src_t'(`FBC_DS_CHANNELS);

	// one byte of the merged output stream with the FIFO it came from
	typedef struct packed {
		src_t                  src;
		logic [`FBC_BYTE_W-1:0] data;
	} fbc_byte_t;

endpackage

/* hdl/async_width_fifo.sv */
`timescale 1ns/1ps
`include "fbc_cfg.svh"

module async_width_fifo #(
	parameter int WORD_W = 32,
	parameter int DEPTH  = 64
) (
	input  logic                                          write_clock,
	input  logic                                          read_clock,
	input  logic                                          rst_n,

	input  logic                                          wr_en,
	input  logic [WORD_W-1:0]                             din,
	output logic                                          full,
	output logic [$clog2(DEPTH):0]                        wr_count,

	input  logic                                          rd_en,
	output logic [`FBC_BYTE_W-1:0]                        dout,
	output logic                                          empty,
	output logic [$clog2(DEPTH*WORD_W/`FBC_BYTE_W):0]     rd_count
);

	localparam int LANES  = WORD_W / `FBC_BYTE_W;
	localparam int LANE_W = $clog2(LANES);
	localparam int AW     = $clog2(DEPTH);
	localparam int RP_W   = AW + LANE_W + 1;

	logic [WORD_W-1:0] mem [DEPTH];

	logic [AW:0]       wr_ptr;
	logic [AW:0]       wr_ptr_nxt;
	logic [AW:0]       wr_gray;
	logic [AW:0]       rd_gray_s1;
	logic [AW:0]       rd_gray_s2;
	logic [AW:0]       rd_ptr_w;
	logic              push;

	logic [RP_W-1:0]   rd_ptr;
	logic [RP_W-1:0]   rd_ptr_nxt;
	logic [AW:0]       rd_gray;
	logic [AW:0]       wr_gray_s1;
	logic [AW:0]       wr_gray_s2;
	logic [AW:0]       wr_ptr_r;
	logic [WORD_W-1:0] rd_word;
	logic              pop;

	function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW - 1; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// write side, one word per accepted write
	assign push       = wr_en && !full;
	assign wr_ptr_nxt = wr_ptr + 1'b1;

	always_ff @(posedge write_clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			wr_gray <= '0;
		end else if (push) begin
			wr_ptr  <= wr_ptr_nxt;
			wr_gray <= bin2gray(wr_ptr_nxt);
		end
	end

	always_ff @(posedge write_clock) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= din;
		end
	end

	always_ff @(posedge write_clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	// a word is only freed once its last byte has been read
	assign rd_ptr_w = gray2bin(rd_gray_s2);
	assign wr_count = wr_ptr - rd_ptr_w;
	assign full     = (wr_count == (AW+1)'(DEPTH));

	// read side, the low pointer bits pick the byte lane
	assign pop        = rd_en && !empty;
	assign rd_ptr_nxt = rd_ptr + 1'b1;
	assign rd_word    = mem[rd_ptr[RP_W-2:LANE_W]];

	always_ff @(posedge read_clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr  <= '0;
			rd_gray <= '0;
		end else if (pop) begin
			rd_ptr  <= rd_ptr_nxt;
			rd_gray <= bin2gray(rd_ptr_nxt[RP_W-1:LANE_W]);
		end
	end

	always_ff @(posedge read_clock) begin
		if (pop) begin
			dout <= rd_word[rd_ptr[LANE_W-1:0]*`FBC_BYTE_W +: `FBC_BYTE_W];
		end
	end

	always_ff @(posedge read_clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	assign wr_ptr_r = gray2bin(wr_gray_s2);
	assign rd_count = {wr_ptr_r, {LANE_W{1'b0}}} - rd_ptr;
	assign empty    = (rd_count == '0);

	// the synchronized read pointer must never let the writer lap it
	assert property (@(posedge write_clock) disable iff (!rst_n)
		wr_count <= (AW+1)'(DEPTH));

	assert property (@(posedge read_clock) disable iff (!rst_n)
		rd_en |-> !empty);

endmodule

/* hdl/stream_merger.sv */
`timescale 1ns/1ps
`include "fbc_cfg.svh"

module stream_merger (
	input  logic                                       read_clock,
	input  logic                                       rst_n,

	input  logic [`FBC_DS_CHANNELS-1:0]                ds_empty,
	input  logic                                       at_empty,
	input  logic [`FBC_DS_CHANNELS*`FBC_BYTE_W-1:0]    ds_dout,
	input  logic [`FBC_BYTE_W-1:0]                     at_dout,
	output logic [`FBC_DS_CHANNELS-1:0]                ds_rd_en,
	output logic                                       at_rd_en,

	output logic                                       out_req,
	output fbc_pkg::fbc_byte_t                         out_data,
	input  logic                                       out_ack
);

	localparam int CH   = `FBC_DS_CHANNELS;
	localparam int CH_W = $clog2(CH);

	typedef enum logic [1:0] {
		S_IDLE,
		S_POP,
		S_PRESENT,
		S_RELEASE
	} state_t;

	state_t          state;
	logic            sel_at;
	logic [CH_W-1:0] last_ds;
	logic [CH_W-1:0] ds_pick;
	logic            ds_hit;

	// nearest nonempty channel after the last one served, wrapping round
	always_comb begin
		logic [CH_W-1:0] idx;
		ds_pick = last_ds;
		ds_hit  = 1'b0;
		for (int i = CH; i >= 1; i--) begin
			idx = last_ds + CH_W'(i);
			if (!ds_empty[idx]) begin
				ds_pick = idx;
				ds_hit  = 1'b1;
			end
		end
	end

	// the pop happens in the selection cycle itself
	assign at_rd_en = (state == S_IDLE) && !at_empty;
	assign ds_rd_en = ((state == S_IDLE) && at_empty && ds_hit) ?
		(CH'(1) << ds_pick) : '0;

	always_ff @(posedge read_clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			sel_at  <= 1'b0;
			last_ds <= CH_W'(CH - 1);
		end else begin
			case (state)
				S_IDLE: begin
					if (!at_empty) begin
						sel_at <= 1'b1;
						state  <= S_POP;
					end else if (ds_hit) begin
						sel_at  <= 1'b0;
						last_ds <= ds_pick;
						state   <= S_POP;
					end
				end
				S_POP: begin
					state <= S_PRESENT;
				end
				S_PRESENT: begin
					if (out_ack) begin
						state <= S_RELEASE;
					end
				end
				default: begin
					if (!out_ack) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// the popped byte lands on dout one cycle after the pop
	always_ff @(posedge read_clock) begin
		if (state == S_POP) begin
			if (sel_at) begin
				out_data.src  <= fbc_pkg::SRC_AT;
				out_data.data <= at_dout;
			end else begin
				out_data.src  <= fbc_pkg::src_t'(last_ds);
				out_data.data <= ds_dout[last_ds*`FBC_BYTE_W +: `FBC_BYTE_W];
			end
		end
	end

	assign out_req = (state == S_PRESENT);

	assert property (@(posedge read_clock) disable iff (!rst_n)
		out_req |=> (!out_req || $stable(out_data)));

	// the consumer must have acknowledged before the request is withdrawn
	assert property (@(posedge read_clock) disable iff (!rst_n)
		$fell(out_req) |-> $past(out_ack));

endmodule

/* hdl/fifo_centre.sv */
`timescale 1ns/1ps
`include "fbc_cfg.svh"

module fifo_centre (
	input  logic                                           write_clock,
	input  logic                                           read_clock,
	input  logic                                           rst_n,

	input  logic [`FBC_DS_CHANNELS-1:0]                    ds_wr_en,
	input  logic [`FBC_DS_CHANNELS*`FBC_DS_WORD_W-1:0]     ds_din,
	input  logic                                           at_wr_en,
	input  logic [`FBC_AT_WORD_W-1:0]                      at_din,

	output logic [`FBC_DS_CHANNELS-1:0]                    ds_full,
	output logic [`FBC_DS_CHANNELS-1:0]                    ds_empty,
	output logic [`FBC_DS_CHANNELS*`FBC_DS_WCNT_W-1:0]     ds_wr_count,
	output logic [`FBC_DS_CHANNELS*`FBC_DS_RCNT_W-1:0]     ds_rd_count,
	output logic                                           at_full,
	output logic                                           at_empty,
	output logic [`FBC_AT_WCNT_W-1:0]                      at_wr_count,
	output logic [`FBC_AT_RCNT_W-1:0]                      at_rd_count,

	output logic                                           out_req,
	output fbc_pkg::fbc_byte_t                             out_data,
	input  logic                                           out_ack
);

	logic [`FBC_DS_CHANNELS-1:0]             ds_rd_en;
	logic [`FBC_DS_CHANNELS*`FBC_BYTE_W-1:0] ds_dout;
	logic                                    at_rd_en;
	logic [`FBC_BYTE_W-1:0]                  at_dout;

	for (genvar i = 0; i < `FBC_DS_CHANNELS; i++) begin : g_ds
		async_width_fifo #(
			.WORD_W (`FBC_DS_WORD_W),
			.DEPTH  (`FBC_DS_DEPTH)
		) u_ds_fifo (
			.write_clock (write_clock),
			.read_clock  (read_clock),
			.rst_n       (rst_n),
			.wr_en       (ds_wr_en[i]),
			.din         (ds_din[i*`FBC_DS_WORD_W +: `FBC_DS_WORD_W]),
			.full        (ds_full[i]),
			.wr_count    (ds_wr_count[i*`FBC_DS_WCNT_W +: `FBC_DS_WCNT_W]),
			.rd_en       (ds_rd_en[i]),
			.dout        (ds_dout[i*`FBC_BYTE_W +: `FBC_BYTE_W]),
			.empty       (ds_empty[i]),
			.rd_count    (ds_rd_count[i*`FBC_DS_RCNT_W +: `FBC_DS_RCNT_W])
		);
	end

	async_width_fifo #(
		.WORD_W (`FBC_AT_WORD_W),
		.DEPTH  (`FBC_AT_DEPTH)
	) u_at_fifo (
		.write_clock (write_clock),
		.read_clock  (read_clock),
		.rst_n       (rst_n),
		.wr_en       (at_wr_en),
		.din         (at_din),
		.full        (at_full),
		.wr_count    (at_wr_count),
		.rd_en       (at_rd_en),
		.dout        (at_dout),
		.empty       (at_empty),
		.rd_count    (at_rd_count)
	);

	stream_merger u_merger (
		.read_clock (read_clock),
		.rst_n      (rst_n),
		.ds_empty   (ds_empty),
		.at_empty   (at_empty),
		.ds_dout    (ds_dout),
		.at_dout    (at_dout),
		.ds_rd_en   (ds_rd_en),
		.at_rd_en   (at_rd_en),
		.out_req    (out_req),
		.out_data   (out_data),
		.out_ack    (out_ack)
	);

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
	parameter real PERIOD_NS = 10.0,
	parameter real OFFSET_NS = 0.0
) (
	output logic clk
);

	// rising edges fall at OFFSET_NS plus whole periods
	initial begin
		clk = 1'b0;
		#(OFFSET_NS);
		forever begin
			clk = 1'b1;
			#(PERIOD_NS / 2.0);
			clk = 1'b0;
			#(PERIOD_NS / 2.0);
		end
	end

endmodule

/* tests/fbc_tb.sv */
`timescale 1ns/1ps
`include "fbc_cfg.svh"

module fbc_tb;

	localparam int CH = `FBC_DS_CHANNELS;
	localparam int DS_BYTES = `FBC_DS_DEPTH * `FBC_DS_WORD_W / `FBC_BYTE_W;
	// roughly 1400 bytes over all phases at no more than about 10 read cycles each
	localparam int TIMEOUT_CYCLES = 20000;

	logic                               write_clock;
	logic                               read_clock;
	logic                               rst_n;
	logic [CH-1:0]                      ds_wr_en;
	logic [CH*`FBC_DS_WORD_W-1:0]       ds_din;
	logic                               at_wr_en;
	logic [`FBC_AT_WORD_W-1:0]          at_din;
	logic [CH-1:0]                      ds_full;
	logic [CH-1:0]                      ds_empty;
	logic [CH*`FBC_DS_WCNT_W-1:0]       ds_wr_count;
	logic [CH*`FBC_DS_RCNT_W-1:0]       ds_rd_count;
	logic                               at_full;
	logic                               at_empty;
	logic [`FBC_AT_WCNT_W-1:0]          at_wr_count;
	logic [`FBC_AT_RCNT_W-1:0]          at_rd_count;
	logic                               out_req;
	fbc_pkg::fbc_byte_t                 out_data;
	logic                               out_ack;

	// one expected byte queue per source with the AT queue at index CH
	logic [`FBC_BYTE_W-1:0]             ref_q [CH+1][$];
	int                                 seed = 23;
	int                                 cycles = 0;
	int                                 presented = 0;
	int                                 last_ds = CH - 1;
	logic                               ack_enable = 1'b0;
	logic                               req_prev = 1'b0;
	logic [`FBC_AT_RCNT_W-1:0]          at_cnt_h0 = '0;
	logic [`FBC_AT_RCNT_W-1:0]          at_cnt_h1 = '0;
	logic [CH-1:0]                      ds_empty_h0 = '1;
	logic [CH-1:0]                      ds_empty_h1 = '1;

	clk_gen #(.PERIOD_NS(10.0), .OFFSET_NS(0.0)) write_clk_gen (.clk(write_clock));
	clk_gen #(.PERIOD_NS(10.0), .OFFSET_NS(3.0)) read_clk_gen (.clk(read_clock));

	fifo_centre DUT (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_eq(input string test, input int expected, input int actual);
		assert (actual == expected)
		else abort_run($sformatf("ERR %s expected 0x%0h actual 0x%0h",
			test, expected, actual));
	endtask

	function automatic int queued_bytes();
		int n = 0;
		for (int s = 0; s <= CH; s++) begin
			n += ref_q[s].size();
		end
		return n;
	endfunction

	// first nonempty DS channel after the last one served in cyclic order
	function automatic int next_ds_channel(input int last, input logic [CH-1:0] empty);
		int idx;
		for (int i = 1; i <= CH; i++) begin
			idx = (last + i) % CH;
			if (!empty[idx]) begin
				return idx;
			end
		end
		return -1;
	endfunction

	task automatic write_cycle(input logic [CH-1:0] ds_en, input logic at_en);
		logic [`FBC_DS_WORD_W-1:0] w;
		logic [`FBC_AT_WORD_W-1:0] a;
		@(posedge write_clock);
		#1;
		for (int ch = 0; ch < CH; ch++) begin
			w = $random(seed);
			ds_din[ch*`FBC_DS_WORD_W +: `FBC_DS_WORD_W] = w;
			if (ds_en[ch] && !ds_full[ch]) begin
				for (int b = 0; b < `FBC_DS_WORD_W / `FBC_BYTE_W; b++) begin
					ref_q[ch].push_back(w[b*`FBC_BYTE_W +: `FBC_BYTE_W]);
				end
			end
		end
		a = $random(seed);
		at_din = a;
		if (at_en && !at_full) begin
			for (int b = 0; b < `FBC_AT_WORD_W / `FBC_BYTE_W; b++) begin
				ref_q[CH].push_back(a[b*`FBC_BYTE_W +: `FBC_BYTE_W]);
			end
		end
		ds_wr_en = ds_en;
		at_wr_en = at_en;
	endtask

	task automatic check_idle(input string test);
		expect_eq(test, 0, out_req);
		for (int ch = 0; ch < CH; ch++) begin
			expect_eq(test, 1, ds_empty[ch]);
			expect_eq(test, 0, ds_full[ch]);
			expect_eq(test, 0, ds_wr_count[ch*`FBC_DS_WCNT_W +: `FBC_DS_WCNT_W]);
			expect_eq(test, 0, ds_rd_count[ch*`FBC_DS_RCNT_W +: `FBC_DS_RCNT_W]);
		end
		expect_eq(test, 1, at_empty);
		expect_eq(test, 0, at_full);
		expect_eq(test, 0, at_wr_count);
		expect_eq(test, 0, at_rd_count);
	endtask

	task automatic wait_drained();
		while (queued_bytes() != 0 || out_req || out_ack) begin
			@(posedge read_clock);
		end
		// the read pointer still has to cross back into the write domain
		repeat (8) @(posedge read_clock);
		#1;
	endtask

	// out_req is first seen high two edges after the selection edge
	always @(posedge read_clock) begin : monitor
		int src;
		if (out_req && !req_prev) begin
			src = out_data.src;
			if (at_cnt_h1 != 0) begin
				expect_eq("at_priority", fbc_pkg::SRC_AT, src);
			end else begin
				expect_eq("round_robin", next_ds_channel(last_ds, ds_empty_h1), src);
				last_ds = src;
			end
			assert (ref_q[src].size() != 0)
			else abort_run($sformatf("source %0d presented a byte that was never written",
				src));
			expect_eq("integrity", ref_q[src].pop_front(), out_data.data);
			presented++;
		end
		req_prev = out_req;
		at_cnt_h1 = at_cnt_h0;
		at_cnt_h0 = at_rd_count;
		ds_empty_h1 = ds_empty_h0;
		ds_empty_h0 = ds_empty;
	end

	always @(posedge read_clock) begin : consumer
		int delay;
		if (ack_enable && out_req && !out_ack) begin
			delay = $unsigned($random(seed)) % 4;
			repeat (delay) @(posedge read_clock);
			#1;
			out_ack = 1'b1;
			do begin
				@(posedge read_clock);
			end while (out_req);
			#1;
			out_ack = 1'b0;
		end
	end

	always @(posedge read_clock) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			abort_run("timeout: the output stream did not drain within the cycle limit");
		end
	end

	initial begin
		rst_n = 1'b0;
		ds_wr_en = '0;
		ds_din = '0;
		at_wr_en = 1'b0;
		at_din = '0;
		out_ack = 1'b0;
		repeat (5) @(posedge write_clock);
		#1;
		rst_n = 1'b1;
		@(posedge read_clock);
		#1;
		check_idle("reset");

		// fill channel 0 while the consumer withholds out_ack
		repeat (`FBC_DS_DEPTH) write_cycle(CH'(1), 1'b0);
		write_cycle('0, 1'b0);
		expect_eq("full", 1, ds_full[0]);
		expect_eq("full", `FBC_DS_DEPTH, ds_wr_count[0 +: `FBC_DS_WCNT_W]);
		write_cycle(CH'(1), 1'b0);
		write_cycle('0, 1'b0);
		expect_eq("full", `FBC_DS_DEPTH, ds_wr_count[0 +: `FBC_DS_WCNT_W]);
		repeat (6) @(posedge read_clock);
		#1;
		expect_eq("full", DS_BYTES, ds_rd_count[0 +: `FBC_DS_RCNT_W] + presented);
		ack_enable = 1'b1;
		wait_drained();

		// every DS channel loaded at once and AT empty
		ack_enable = 1'b0;
		repeat (8) write_cycle('1, 1'b0);
		write_cycle('0, 1'b0);
		ack_enable = 1'b1;
		wait_drained();

		repeat (48) write_cycle(CH'($random(seed)), 1'($random(seed)));
		write_cycle('0, 1'b0);
		wait_drained();
		check_idle("drain");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hdl
hdl/fbc_pkg.sv
hdl/async_width_fifo.sv
hdl/stream_merger.sv
hdl/fifo_centre.sv
tests/clk_gen.sv
tests/fbc_tb.sv

/* Bender.yml */
package:
  name: fbc_fifo_centre

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fbc_pkg.sv
      - hdl/async_width_fifo.sv
      - hdl/stream_merger.sv
      - hdl/fifo_centre.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/clk_gen.sv
      - tests/fbc_tb.sv
